// ==== source/mul_pkg.sv ====
/* shared widths, register map, types and structs of the multiply unit.
   every other source file refers to these by scoped names. */

package mul_pkg;

    // ============================================================
    // widths and counts
    // ============================================================
    localparam int XLEN            = 32;
    localparam int EXT_W           = 36;   // operand after sign or zero extension.
    localparam int PROD_W          = 64;
    localparam int DIGITS_PER_STEP = 6;
    localparam int NUM_STEPS       = 3;    // 18 booth digits in total.

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [EXT_W-1:0]  ext_word_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [1:0]        step_t;

    // ============================================================
    // register map
    // ============================================================
    localparam word_t REG_A      = 32'h0000_0000;
    localparam word_t REG_B      = 32'h0000_0004;
    localparam word_t REG_CTRL   = 32'h0000_0008;  // a write here starts the operation.
    localparam word_t REG_RESULT = 32'h0000_000C;
    localparam word_t REG_STATUS = 32'h0000_0010;  // bit 0 busy, bit 1 done.

    typedef enum logic [1:0] {
        MUL    = 2'd0,
        MULH   = 2'd1,
        MULHSU = 2'd2,
        MULHU  = 2'd3
    } mul_op_e;

    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_STEP   = 2'd1,
        S_FINISH = 2'd2,
        S_DONE   = 2'd3
    } mul_state_e;

    // six shifted partial products of one reduction step.
    typedef struct packed {
        prod_t [DIGITS_PER_STEP-1:0] row;
    } pp_group_t;

    typedef struct packed {
        prod_t sum;
        prod_t carry;
    } csa_acc_t;

    typedef struct packed {
        ext_word_t a;
        ext_word_t b;
        mul_op_e   op;
    } mul_cmd_t;

endpackage

// ==== source/booth_digit_encoder.sv ====
/* radix-4 modified booth recoder for one step of six digits.
   each digit picks 0, +-a or +-2a, sign-extended to 64 bits and shifted into place. */
`timescale 1ns/10ps

module booth_digit_encoder (
    input  mul_pkg::mul_cmd_t  cmd_i,
    input  mul_pkg::step_t     step_i,
    output mul_pkg::pp_group_t pp_o
);

    logic [mul_pkg::EXT_W:0] b_ext;   // multiplier with a zero appended below bit 0.
    mul_pkg::prod_t          a_pos;
    mul_pkg::prod_t          a_dbl;
    mul_pkg::prod_t          row;
    logic [2:0]              window;
    int                      digit;

    assign b_ext = {cmd_i.b, 1'b0};
    assign a_pos = {{(mul_pkg::PROD_W-mul_pkg::EXT_W){cmd_i.a[mul_pkg::EXT_W-1]}}, cmd_i.a};
    assign a_dbl = a_pos << 1;

    always_comb begin
        pp_o   = '0;
        row    = '0;
        window = 3'b000;
        digit  = 0;
        for (int k = 0; k < mul_pkg::DIGITS_PER_STEP; k++) begin
            digit = int'(step_i) * mul_pkg::DIGITS_PER_STEP + k;
            // digits past the last step never reach the accumulator.
            if (digit < mul_pkg::DIGITS_PER_STEP * mul_pkg::NUM_STEPS) begin
                window = b_ext[2*digit +: 3];
            end else begin
                window = 3'b000;
            end
            case (window)
                3'b001, 3'b010: row = a_pos;
                3'b011:         row = a_dbl;
                3'b100:         row = ~a_dbl + 64'd1;   // -2a.
                3'b101, 3'b110: row = ~a_pos + 64'd1;   // -a.
                default:        row = '0;               // 000 and 111 give zero.
            endcase
            pp_o.row[k] = row << (2 * digit);
        end
    end

endmodule

// ==== source/mul_csa_accumulator.sv ====
/* carry-save accumulator of the partial products, with the final carry-propagate add.
   each step folds six rows plus the stored sum and carry back down to two rows. */
`timescale 1ns/10ps

module mul_csa_accumulator (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               load_i,
    input  logic               step_i,
    input  logic               finish_i,
    input  mul_pkg::pp_group_t pp_i,
    output mul_pkg::prod_t     product_o
);

    mul_pkg::csa_acc_t acc_q;
    mul_pkg::csa_acc_t lvl1_a;
    mul_pkg::csa_acc_t lvl1_b;
    mul_pkg::csa_acc_t lvl2_a;
    mul_pkg::csa_acc_t lvl2_b;
    mul_pkg::csa_acc_t lvl3;
    mul_pkg::csa_acc_t lvl4;

    // one row of 3:2 compressors; the carry row is weighted one bit higher.
    function automatic mul_pkg::csa_acc_t compress(input mul_pkg::prod_t x,
                                                   input mul_pkg::prod_t y,
                                                   input mul_pkg::prod_t z);
        mul_pkg::csa_acc_t res;
        res.sum   = x ^ y ^ z;
        res.carry = ((x & y) | (x & z) | (y & z)) << 1;
        return res;
    endfunction

    // ============================================================
    // eight rows to two, in four levels
    // ============================================================
    assign lvl1_a = compress(pp_i.row[0], pp_i.row[1], pp_i.row[2]);
    assign lvl1_b = compress(pp_i.row[3], pp_i.row[4], pp_i.row[5]);
    assign lvl2_a = compress(lvl1_a.sum, lvl1_a.carry, lvl1_b.sum);
    assign lvl2_b = compress(lvl1_b.carry, acc_q.sum, acc_q.carry);
    assign lvl3   = compress(lvl2_a.sum, lvl2_a.carry, lvl2_b.sum);
    assign lvl4   = compress(lvl3.sum, lvl3.carry, lvl2_b.carry);

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            acc_q <= '0;
        end else if (step_i) begin
            acc_q <= lvl4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            product_o <= '0;
        end else if (finish_i) begin
            product_o <= acc_q.sum + acc_q.carry;   // the only carry-propagate add.
        end
    end

endmodule

// ==== source/mul_step_counter.sv ====
/* index of the current reduction step; selects which six booth digits are encoded. */
`timescale 1ns/10ps

module mul_step_counter (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           load_i,
    input  logic           step_i,
    output mul_pkg::step_t step_o,
    output logic           last_step_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            step_o <= '0;
        end else if (load_i) begin
            step_o <= '0;                 // a new operation starts at digit group 0.
        end else if (step_i) begin
            step_o <= step_o + 2'd1;
        end
    end

    assign last_step_o = (step_o == mul_pkg::step_t'(mul_pkg::NUM_STEPS - 1));

endmodule

// ==== source/mul_control_fsm.sv ====
/* sequencer of one multiply: idle, three steps, finish, done.
   issues the load, step and finish strobes to the datapath. */
`timescale 1ns/10ps

module mul_control_fsm (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic last_step_i,
    output logic load_o,
    output logic step_o,
    output logic finish_o,
    output logic busy_o,
    output logic done_o
);

    mul_pkg::mul_state_e state_q;
    mul_pkg::mul_state_e state_d;
    logic                accept;

    // a new start is taken only when no operation is running.
    assign accept = start_i &&
                    (state_q == mul_pkg::S_IDLE || state_q == mul_pkg::S_DONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mul_pkg::S_IDLE,
            mul_pkg::S_DONE: begin
                if (accept) begin
                    state_d = mul_pkg::S_STEP;
                end
            end
            mul_pkg::S_STEP: begin
                if (last_step_i) begin
                    state_d = mul_pkg::S_FINISH;
                end
            end
            default: state_d = mul_pkg::S_DONE;   // S_FINISH lasts a single cycle.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= mul_pkg::S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign load_o   = accept;   // clears the accumulator on the edge that enters S_STEP.
    assign step_o   = (state_q == mul_pkg::S_STEP);
    assign finish_o = (state_q == mul_pkg::S_FINISH);
    assign busy_o   = step_o | finish_o;
    assign done_o   = (state_q == mul_pkg::S_DONE);   // held until the next start.

endmodule

// ==== source/mul_wb_regs.sv ====
/* wishbone classic slave with the operand, control, result and status registers.
   one-cycle ack with no wait states; operand writes are dropped while a multiply runs. */
`timescale 1ns/10ps

module mul_wb_regs (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  mul_pkg::word_t    wb_adr_i,
    input  mul_pkg::word_t    wb_dat_i,
    input  logic [3:0]        wb_sel_i,
    output mul_pkg::word_t    wb_dat_o,
    output logic              wb_ack_o,
    input  logic              busy_i,
    input  logic              done_i,
    input  mul_pkg::prod_t    product_i,
    output logic              start_o,
    output mul_pkg::mul_cmd_t cmd_o
);

    logic              access;
    logic              wr_ok;
    logic              a_signed;
    logic              b_signed;
    mul_pkg::word_t    op_a_q;
    mul_pkg::word_t    op_b_q;
    mul_pkg::mul_op_e  op_q;
    mul_pkg::word_t    rd_data;

    assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr_ok  = access & wb_we_i & ~busy_i;

    // ============================================================
    // bus handshake and start pulse
    // ============================================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            start_o  <= 1'b0;
            op_q     <= mul_pkg::MUL;
        end else begin
            wb_ack_o <= access;            // every access is acknowledged, busy or not.
            start_o  <= wr_ok && (wb_adr_i == mul_pkg::REG_CTRL);
            if (wr_ok && wb_adr_i == mul_pkg::REG_CTRL) begin
                op_q <= mul_pkg::mul_op_e'(wb_dat_i[1:0]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_ok && wb_sel_i[i] && wb_adr_i == mul_pkg::REG_A) begin
                op_a_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
            if (wr_ok && wb_sel_i[i] && wb_adr_i == mul_pkg::REG_B) begin
                op_b_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
        end
    end

    // ============================================================
    // read mux
    // ============================================================
    always_comb begin
        case (wb_adr_i)
            mul_pkg::REG_A:      rd_data = op_a_q;
            mul_pkg::REG_B:      rd_data = op_b_q;
            mul_pkg::REG_CTRL:   rd_data = {30'd0, op_q};
            mul_pkg::REG_RESULT: rd_data = (op_q == mul_pkg::MUL) ? product_i[31:0]
                                                                   : product_i[63:32];
            mul_pkg::REG_STATUS: rd_data = {30'd0, done_i, busy_i};
            default:             rd_data = '0;   // unmapped.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (access && !wb_we_i) begin
            wb_dat_o <= rd_data;   // valid in the same cycle as ack.
        end
    end

    // signed a for MULH and MULHSU, signed b for MULH only.
    assign a_signed = (op_q == mul_pkg::MULH) || (op_q == mul_pkg::MULHSU);
    assign b_signed = (op_q == mul_pkg::MULH);

    assign cmd_o.a  = {{(mul_pkg::EXT_W-mul_pkg::XLEN){a_signed & op_a_q[31]}}, op_a_q};
    assign cmd_o.b  = {{(mul_pkg::EXT_W-mul_pkg::XLEN){b_signed & op_b_q[31]}}, op_b_q};
    assign cmd_o.op = op_q;

endmodule

// ==== source/mul_unit_top.sv ====
/* top level of the multiply unit: wishbone register block, sequencer and booth datapath. */
`timescale 1ns/10ps

module mul_unit_top (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           wb_cyc_i,
    input  logic           wb_stb_i,
    input  logic           wb_we_i,
    input  mul_pkg::word_t wb_adr_i,
    input  mul_pkg::word_t wb_dat_i,
    input  logic [3:0]     wb_sel_i,
    output mul_pkg::word_t wb_dat_o,
    output logic           wb_ack_o
);

    logic               start;
    logic               load;
    logic               step_en;
    logic               finish;
    logic               busy;
    logic               done;
    logic               last_step;
    mul_pkg::step_t     step_idx;
    mul_pkg::mul_cmd_t  cmd;
    mul_pkg::pp_group_t pp_group;
    mul_pkg::prod_t     product;

    mul_wb_regs i_mul_wb_regs (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .busy_i    (busy),
        .done_i    (done),
        .product_i (product),
        .start_o   (start),
        .cmd_o     (cmd)
    );

    mul_control_fsm i_mul_control_fsm (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (start),
        .last_step_i (last_step),
        .load_o      (load),
        .step_o      (step_en),
        .finish_o    (finish),
        .busy_o      (busy),
        .done_o      (done)
    );

    mul_step_counter i_mul_step_counter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (load),
        .step_i      (step_en),
        .step_o      (step_idx),
        .last_step_o (last_step)
    );

    booth_digit_encoder i_booth_digit_encoder (
        .cmd_i  (cmd),
        .step_i (step_idx),
        .pp_o   (pp_group)
    );

    mul_csa_accumulator i_mul_csa_accumulator (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .load_i    (load),
        .step_i    (step_en),
        .finish_i  (finish),
        .pp_i      (pp_group),
        .product_o (product)
    );

endmodule

// ==== bench/mul_unit_checker.sv ====
/* concurrent assertions on the wishbone handshake and the multiply sequencing.
   bound into the top level, so it sees the internal start, busy and done wires. */
`timescale 1ns/10ps

module mul_unit_checker (
    input logic clk_i,
    input logic rst_n_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic start_i,
    input logic busy_i,
    input logic done_i
);

    ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_i |=> !wb_ack_i)
        else $error("wishbone ack stayed high for more than one cycle");

    ack_follows_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
        else $error("wishbone ack raised without a cycle and strobe");

    // start is seen one edge after the ack, done five edges after that.
    done_after_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> ##5 done_i)
        else $error("done did not follow start after five cycles");

    start_clears_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |=> !done_i)
        else $error("done still high in the cycle after start");

    // busy covers the three steps and the finish cycle, then gives way to done.
    busy_then_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |=> (busy_i && !done_i) ##1 (busy_i && !done_i) ##1 (busy_i && !done_i)
                    ##1 (busy_i && !done_i) ##1 (done_i && !busy_i))
        else $error("busy and done did not follow the step and finish sequence");

endmodule

bind mul_unit_top mul_unit_checker i_mul_unit_checker (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_i (wb_ack_o),
    .start_i  (start),
    .busy_i   (busy),
    .done_i   (done)
);

// ==== bench/mul_unit_tb.sv ====
/* directed testbench of the multiply unit, driven over its wishbone port.
   results are checked against a 64-bit software multiply, status against the sequencer timing. */
`timescale 1ns/10ps

module mul_unit_tb;

    localparam int NUM_PAIRS       = 9;
    localparam int NUM_RANDOM      = 50;
    localparam int NUM_OPERATIONS  = 4 * NUM_PAIRS + NUM_RANDOM + 6;
    localparam int ACCESSES_PER_OP = 8;   // three writes, status polls and the result read.
    localparam int TIMEOUT_CYCLES  = NUM_OPERATIONS * ACCESSES_PER_OP * 20;

    localparam mul_pkg::word_t DIR_A [NUM_PAIRS] = '{
        32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000, 32'h8000_0000,
        32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'hFFFF_FFF9, 32'h1234_5678
    };
    localparam mul_pkg::word_t DIR_B [NUM_PAIRS] = '{
        32'h9ABC_DEF0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF,
        32'h7FFF_FFFF, 32'h8000_0000, 32'h0000_0003, 32'hFEDC_BA98
    };

    logic           clk;
    logic           rst_n;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    mul_pkg::word_t wb_adr;
    mul_pkg::word_t wb_dat_w;
    logic [3:0]     wb_sel;
    mul_pkg::word_t wb_dat_r;
    logic           wb_ack;
    int             cycle_cnt   = 0;
    int             ack_cycle   = 0;
    int             check_count = 0;
    int             error_count = 0;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    mul_unit_top i_mul_unit_top (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    // ============================================================
    // reference model and compare tasks
    // ============================================================
    function automatic mul_pkg::word_t expected_result(input mul_pkg::mul_op_e op,
                                                       input mul_pkg::word_t   a,
                                                       input mul_pkg::word_t   b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     prod;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = {32'd0, a};
        ub = {32'd0, b};
        case (op)
            mul_pkg::MULHSU: prod = sa * ub;   // signed times unsigned.
            mul_pkg::MULHU:  prod = ua * ub;
            default:         prod = sa * sb;
        endcase
        if (op == mul_pkg::MUL) begin
            return prod[31:0];
        end else begin
            return prod[63:32];
        end
    endfunction

    // the bytes enabled by sel come from the new value, the rest stay.
    function automatic mul_pkg::word_t merge_bytes(input mul_pkg::word_t old_val,
                                                   input mul_pkg::word_t new_val,
                                                   input logic [3:0]     sel);
        mul_pkg::word_t res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic compare_word(input string name, input mul_pkg::word_t got,
                                input mul_pkg::word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic compare_status(input mul_pkg::word_t got, input logic busy_exp,
                                  input logic done_exp);
        mul_pkg::word_t exp;
        exp = {30'd0, done_exp, busy_exp};
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED status: got 0x%08h, expected 0x%08h", got, exp);
        end
    endtask

    // ============================================================
    // bus tasks
    // ============================================================
    task automatic wait_for_ack();
        @(posedge clk);
        #10;
        while (!wb_ack) begin
            @(posedge clk);
            #10;
        end
        ack_cycle = cycle_cnt;   // index of the edge that raised ack.
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
    endtask

    task automatic wb_write(input mul_pkg::word_t adr, input mul_pkg::word_t dat,
                            input logic [3:0] sel);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        wait_for_ack();
    endtask

    task automatic wb_read(input mul_pkg::word_t adr, output mul_pkg::word_t dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wb_sel = 4'hF;
        wait_for_ack();
        dat = wb_dat_r;
    endtask

    // status read sampled by the dut on a chosen edge.
    task automatic read_status_at(input int edge_idx, output mul_pkg::word_t st);
        while (cycle_cnt < edge_idx - 1) begin
            @(posedge clk);
            #10;
        end
        wb_read(mul_pkg::REG_STATUS, st);
        if (ack_cycle != edge_idx) begin
            error_count++;
            $display("status read was sampled on edge %0d instead of edge %0d",
                     ack_cycle, edge_idx);
        end
    endtask

    task automatic wait_done();
        mul_pkg::word_t st;
        wb_read(mul_pkg::REG_STATUS, st);
        while (!st[1]) begin
            wb_read(mul_pkg::REG_STATUS, st);
        end
    endtask

    task automatic multiply_and_check(input mul_pkg::mul_op_e op, input mul_pkg::word_t a,
                                      input mul_pkg::word_t b);
        mul_pkg::word_t got;
        wb_write(mul_pkg::REG_A, a, 4'hF);
        wb_write(mul_pkg::REG_B, b, 4'hF);
        wb_write(mul_pkg::REG_CTRL, {30'd0, op}, 4'hF);
        wait_done();
        wb_read(mul_pkg::REG_RESULT, got);
        compare_word($sformatf("%s result a=%08h b=%08h", op.name(), a, b), got,
                     expected_result(op, a, b));
    endtask

    // ============================================================
    // tests
    // ============================================================
    task automatic test_reset_state();
        mul_pkg::word_t got;
        wb_read(mul_pkg::REG_STATUS, got);
        compare_status(got, 1'b0, 1'b0);
        wb_read(mul_pkg::REG_RESULT, got);
        compare_word("result after reset", got, '0);
    endtask

    task automatic test_directed_operands();
        mul_pkg::mul_op_e op;
        for (int o = 0; o < 4; o++) begin
            op = mul_pkg::mul_op_e'(o[1:0]);
            for (int p = 0; p < NUM_PAIRS; p++) begin
                multiply_and_check(op, DIR_A[p], DIR_B[p]);
            end
        end
    endtask

    task automatic test_random_operands();
        mul_pkg::word_t a;
        mul_pkg::word_t b;
        logic [1:0]     op_bits;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            a       = $urandom();
            b       = $urandom();
            op_bits = 2'($urandom_range(3, 0));
            multiply_and_check(mul_pkg::mul_op_e'(op_bits), a, b);
        end
    endtask

    // done rises on the edge ack+5, so a status read first sees it on edge ack+6.
    task automatic test_status_sequence();
        mul_pkg::word_t st;
        mul_pkg::word_t got;
        int             start_edge;
        wb_write(mul_pkg::REG_A, 32'hFFFF_FFFE, 4'hF);
        wb_write(mul_pkg::REG_B, 32'h0000_0003, 4'hF);
        wb_write(mul_pkg::REG_CTRL, {30'd0, mul_pkg::MULH}, 4'hF);
        start_edge = ack_cycle;
        read_status_at(start_edge + 2, st);   // first edge a new access can land on.
        compare_status(st, 1'b1, 1'b0);
        read_status_at(start_edge + 5, st);   // the finish cycle, still busy.
        compare_status(st, 1'b1, 1'b0);
        wait_done();
        wb_read(mul_pkg::REG_RESULT, got);
        compare_word("MULH result", got,
                     expected_result(mul_pkg::MULH, 32'hFFFF_FFFE, 32'h0000_0003));
        wb_write(mul_pkg::REG_CTRL, {30'd0, mul_pkg::MUL}, 4'hF);
        start_edge = ack_cycle;
        read_status_at(start_edge + 6, st);
        compare_status(st, 1'b0, 1'b1);
    endtask

    task automatic test_writes_while_busy();
        mul_pkg::word_t got;
        wb_write(mul_pkg::REG_A, 32'hC000_0001, 4'hF);
        wb_write(mul_pkg::REG_B, 32'h7654_3210, 4'hF);
        wb_write(mul_pkg::REG_CTRL, {30'd0, mul_pkg::MULHU}, 4'hF);
        wb_write(mul_pkg::REG_A, 32'hDEAD_BEEF, 4'hF);   // both land while busy.
        wb_write(mul_pkg::REG_B, 32'h0BAD_F00D, 4'hF);
        wait_done();
        wb_read(mul_pkg::REG_RESULT, got);
        compare_word("MULHU result after busy writes", got,
                     expected_result(mul_pkg::MULHU, 32'hC000_0001, 32'h7654_3210));
        wb_read(mul_pkg::REG_A, got);
        compare_word("operand a after busy write", got, 32'hC000_0001);
        wb_read(mul_pkg::REG_B, got);
        compare_word("operand b after busy write", got, 32'h7654_3210);
    endtask

    task automatic test_byte_select();
        mul_pkg::word_t a_exp;
        mul_pkg::word_t got;
        a_exp = 32'h1122_3344;
        wb_write(mul_pkg::REG_A, a_exp, 4'hF);
        wb_write(mul_pkg::REG_A, 32'hAABB_CCDD, 4'b0101);
        a_exp = merge_bytes(a_exp, 32'hAABB_CCDD, 4'b0101);
        wb_read(mul_pkg::REG_A, got);
        compare_word("operand a after sel 0101", got, a_exp);
        wb_write(mul_pkg::REG_A, 32'h80FF_FFFF, 4'b1000);
        a_exp = merge_bytes(a_exp, 32'h80FF_FFFF, 4'b1000);
        wb_read(mul_pkg::REG_A, got);
        compare_word("operand a after sel 1000", got, a_exp);
        wb_write(mul_pkg::REG_B, 32'h0001_0003, 4'hF);
        wb_write(mul_pkg::REG_CTRL, {30'd0, mul_pkg::MUL}, 4'hF);
        wait_done();
        wb_read(mul_pkg::REG_RESULT, got);
        compare_word("MUL result after byte writes", got,
                     expected_result(mul_pkg::MUL, a_exp, 32'h0001_0003));
    endtask

    // ============================================================
    // main sequence and watchdog
    // ============================================================
    initial begin
        void'($urandom(45));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = 4'h0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;

        test_reset_state();
        test_directed_operands();
        test_random_operands();
        test_status_sequence();
        test_writes_while_busy();
        test_byte_select();

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks run: %0d, errors: %0d", check_count, error_count + 1);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
source/mul_pkg.sv
source/booth_digit_encoder.sv
source/mul_csa_accumulator.sv
source/mul_step_counter.sv
source/mul_control_fsm.sv
source/mul_wb_regs.sv
source/mul_unit_top.sv
bench/mul_unit_checker.sv
bench/mul_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the multiply unit testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module mul_unit_tb \
    -f sources.f \
    --Mdir obj_dir -o mul_unit_sim

./obj_dir/mul_unit_sim | tee "$LOG"

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
